/* rvCore.f */
rtl/rvCorePkg.sv
rtl/controlUnit.sv
rtl/immGen.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/instrMem.sv
rtl/dataMem.sv
rtl/rvCore.sv
tests/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the rvCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module rvCoreTb \
    -f rvCore.f -o rvCoreTb

output=$(./obj_dir/rvCoreTb)
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

/* tests/rvCoreTb.sv */
`timescale 1ns/1ns

module rvCoreTb
    import rvCorePkg::*;
();

    localparam int clockPeriod    = 4;
    localparam int resetCycles    = 10;
    localparam int numProgs       = 8;
    localparam int progLen        = 64;
    localparam int runCycles      = 80;
    localparam int sampleDelay    = 1;     // Quarter period after the falling edge
    localparam int watchdogCycles = 2 * (numProgs * (progLen + runCycles) + resetCycles);

    logic        clock = 1'b0;
    logic        arstN;
    logic        run;
    logic        loadValid;
    logic        loadReady;
    logic [7:0]  loadAddr;
    logic [31:0] loadData;
    logic        commitValid;
    logic [4:0]  commitReg;
    logic [31:0] commitData;
    logic [7:0]  commitPc;

    // Reference state, kept across programs like the DUT
    logic [31:0] progMem [imemWords];
    logic [31:0] mRegs [32];
    logic [7:0]  mMem [dmemBytes];
    logic [7:0]  mPc;
    logic [31:0] seed;
    int          errorCount;
    int          commitTotal;

    rvCore i_rvCore (
        .clock      (clock),
        .arstN      (arstN),
        .run        (run),
        .loadValid  (loadValid),
        .loadReady  (loadReady),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .commitValid(commitValid),
        .commitReg  (commitReg),
        .commitData (commitData),
        .commitPc   (commitPc)
    );

    initial begin
        forever #(clockPeriod / 2) clock = ~clock;
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout after %0d clock periods, the run did not finish", watchdogCycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
        return seed;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("Error %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    // One random instruction of any supported kind
    function automatic logic [31:0] randInstr();
        logic [31:0] f;
        logic [31:0] g;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [4:0]  memRs1;
        logic [11:0] memImm;
        logic [3:0]  off;
        logic [2:0]  f3;
        logic [2:0]  ldF3;
        logic [2:0]  stF3;
        f      = nextRand();
        g      = nextRand();
        rs1    = f[4:0];
        rs2    = f[9:5];
        rd     = (f[17:15] == 3'd0) ? 5'd0 : f[14:10];   // x0 target one time in eight
        imm    = f[29:18];
        memRs1 = f[31] ? 5'd0 : rs1;                      // Half the accesses hit low 64 bytes
        memImm = f[31] ? {6'd0, imm[5:0]} : imm;
        off    = {2'b00, g[1:0]} + 4'd1;                  // Forward 1 to 4 words
        f3     = g[4:2];
        ldF3   = (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111) ? 3'b010 : f3;
        stF3   = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
        case (g[31:28])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                return {1'b0, (f3 == 3'b000 || f3 == 3'b101) & g[5], 5'd0,
                        rs2, rs1, f3, rd, opR};           // sub and sra through bit 30
            end
            4'd4, 4'd5, 4'd6, 4'd7: begin
                if (f3 == 3'b001) imm = {7'd0, imm[4:0]};             // slli
                else if (f3 == 3'b101) imm = {1'b0, g[5], 5'd0, imm[4:0]};   // srli, srai
                return {imm, rs1, f3, rd, opI};
            end
            4'd8, 4'd9:   return {memImm, memRs1, ldF3, rd, opLoad};
            4'd10, 4'd11: return {memImm[11:5], rs2, memRs1, stF3, memImm[4:0], opStore};
            4'd12: return {1'b0, 6'd0, g[5] ? rs1 : rs2, rs1, f3Beq, off, 1'b0, opBranch};
            4'd13: return {1'b0, 6'd0, g[5] ? rs1 : rs2, rs1, f3Bne, off, 1'b0, opBranch};
            4'd14: return {1'b0, 6'd0, off, 1'b0, 8'd0, rd, opJal};
            default: return {g[27:8], rd, opLui};
        endcase
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'd0, $signed(x) < $signed(y)};
            3'b011:  return {31'd0, x < y};
            3'b100:  return x ^ y;
            3'b101:  return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    // Little endian, 10-bit wrap
    function automatic logic [31:0] loadRef(input logic [9:0] addr, input logic [2:0] f3);
        logic [31:0] word;
        word = {mMem[addr + 10'd3], mMem[addr + 10'd2], mMem[addr + 10'd1], mMem[addr]};
        case (f3)
            3'b000:  return {{24{word[7]}}, word[7:0]};     // lb
            3'b001:  return {{16{word[15]}}, word[15:0]};   // lh
            3'b100:  return {24'd0, word[7:0]};             // lbu
            3'b101:  return {16'd0, word[15:0]};            // lhu
            default: return word;
        endcase
    endfunction

    task automatic storeRef(input logic [9:0] addr, input logic [2:0] f3,
                            input logic [31:0] data);
        mMem[addr] = data[7:0];
        if (f3 != 3'b000) mMem[addr + 10'd1] = data[15:8];
        if (f3 == 3'b010) begin
            mMem[addr + 10'd2] = data[23:16];
            mMem[addr + 10'd3] = data[31:24];
        end
    endtask

    // Executes one instruction at mPc and predicts its commit
    task automatic modelStep(output logic wrote, output logic [4:0] rd,
                             output logic [31:0] val);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] offB;
        logic [31:0] offJ;
        logic [31:0] sum;
        logic [2:0]  f3;
        logic [7:0]  nextPc;
        logic        wr;
        ins    = progMem[mPc];
        f3     = ins[14:12];
        rd     = ins[11:7];
        a      = mRegs[ins[19:15]];
        b      = mRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        offB   = {{20{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8]};     // In words
        offJ   = {{12{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21]};
        nextPc = mPc + 8'd1;
        wr     = 1'b0;
        val    = 32'd0;
        sum    = 32'd0;
        case (ins[6:0])
            opR: begin
                wr  = 1'b1;
                val = aluRef(f3, ins[30], a, b);
            end
            opI: begin
                wr  = 1'b1;
                val = aluRef(f3, ins[30] && (f3 == 3'b101), a, immI);   // No subi
            end
            opLoad: begin
                sum = a + immI;
                wr  = 1'b1;
                val = loadRef(sum[9:0], f3);
            end
            opStore: begin
                sum = a + immS;
                storeRef(sum[9:0], f3, b);
            end
            opBranch: begin
                if ((f3 == f3Beq && a == b) || (f3 == f3Bne && a != b)) nextPc = mPc + offB[7:0];
            end
            opJal: begin
                wr     = 1'b1;
                val    = {24'd0, mPc + 8'd1};       // Link in words
                nextPc = mPc + offJ[7:0];
            end
            opLui: begin
                wr  = 1'b1;
                val = {ins[31:12], 12'd0};
            end
            default: ;                              // No-op
        endcase
        wrote = wr && (rd != 5'd0);
        if (wrote) mRegs[rd] = val;
        mPc = nextPc;
    endtask

    task automatic genProgram();
        for (int i = 0; i < progLen; i++) begin
            progMem[i] = randInstr();
        end
    endtask

    // Valid/ready transfer of each word while stopped
    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(negedge clock);
            loadValid = 1'b1;
            loadAddr  = i[7:0];
            loadData  = progMem[i];
            #sampleDelay;
            // Word 0 sits at pc 0 while stopped, no commit allowed
            if (commitValid !== 1'b0) begin
                reportMismatch($sformatf("load word %0d commitValid", i), 32'd0,
                               {31'd0, commitValid});
            end
            while (loadReady !== 1'b1) begin
                @(negedge clock);
                #sampleDelay;
            end
        end
    endtask

    task automatic runProgram(input int prog);
        logic        expValid;
        logic [4:0]  expReg;
        logic [31:0] expData;
        logic [7:0]  expPc;
        logic [31:0] junk;
        int          dutCommits;
        int          modelCommits;
        string       name;
        dutCommits   = 0;
        modelCommits = 0;
        mPc          = 8'd0;                 // DUT pc was cleared while stopped
        for (int c = 0; c < runCycles; c++) begin
            @(negedge clock);
            junk      = nextRand();
            run       = 1'b1;
            loadValid = 1'b1;                // Rejected load, would corrupt the program
            loadAddr  = junk[7:0];
            loadData  = nextRand();
            #sampleDelay;
            name = $sformatf("prog %0d cycle %0d", prog, c);
            if (loadReady !== 1'b0) begin
                reportMismatch({name, " loadReady"}, 32'd0, {31'd0, loadReady});
            end
            expPc = mPc;
            modelStep(expValid, expReg, expData);
            if (expValid) modelCommits++;
            if (commitValid === 1'b1) dutCommits++;
            if (commitValid !== expValid) begin
                reportMismatch({name, " commitValid"}, {31'd0, expValid}, {31'd0, commitValid});
            end else if (expValid) begin
                if (commitReg !== expReg) begin
                    reportMismatch({name, " commitReg"}, {27'd0, expReg}, {27'd0, commitReg});
                end
                if (commitData !== expData) begin
                    reportMismatch({name, " commitData"}, expData, commitData);
                end
                if (commitPc !== expPc) begin
                    reportMismatch({name, " commitPc"}, {24'd0, expPc}, {24'd0, commitPc});
                end
            end
        end
        @(negedge clock);
        run       = 1'b0;
        loadValid = 1'b0;
        #sampleDelay;
        name = $sformatf("prog %0d stopped", prog);
        if (loadReady !== 1'b1) reportMismatch({name, " loadReady"}, 32'd1, {31'd0, loadReady});
        if (dutCommits != modelCommits) begin
            reportMismatch({name, " commit count"}, modelCommits, dutCommits);
        end
        commitTotal += dutCommits;
    endtask

    initial begin
        run         = 1'b0;
        loadValid   = 1'b0;
        loadAddr    = 8'd0;
        loadData    = 32'd0;
        arstN       = 1'b0;
        seed        = 32'h1b2cbbf8;
        errorCount  = 0;
        commitTotal = 0;
        mPc         = 8'd0;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = 32'd0;
        end
        for (int i = 0; i < dmemBytes; i++) begin
            mMem[i] = 8'd0;
        end
        for (int i = 0; i < imemWords; i++) begin
            progMem[i] = 32'd0;              // Unloaded words are no-ops
        end

        repeat (resetCycles) @(negedge clock);
        arstN = 1'b1;
        #sampleDelay;
        if (commitValid !== 1'b0) reportMismatch("reset commitValid", 32'd0, {31'd0, commitValid});
        if (loadReady !== 1'b1) reportMismatch("reset loadReady", 32'd1, {31'd0, loadReady});

        for (int p = 0; p < numProgs; p++) begin
            genProgram();
            loadProgram();
            runProgram(p);
        end

        $display("Checked %0d programs and %0d commits, %0d errors",
                 numProgs, commitTotal, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* rtl/rvCore.sv */
`timescale 1ns/1ns

module rvCore
    import rvCorePkg::*;
(
    input  logic        clock,
    input  logic        arstN,
    input  logic        run,
    input  logic        loadValid,
    output logic        loadReady,
    input  logic [7:0]  loadAddr,
    input  logic [31:0] loadData,
    output logic        commitValid,
    output logic [4:0]  commitReg,
    output logic [31:0] commitData,
    output logic [7:0]  commitPc
);

    instrWord    instr;
    logic        regWrite, memWrite, memRead, aluSrc;
    logic        branch, branchNe, jump, loadUnsigned;
    logic [1:0]  aluOp, wbSel, memSize;
    logic [31:0] imm, readData1, readData2, aluB, aluResult, memData, writeData;
    logic        zero;
    logic [7:0]  pc, pcPlus1, pcNext;
    logic        takeBranch;
    logic [4:0]  rd;

    assign rd = instr.rType.rd;

    // Loading only while stopped
    assign loadReady = ~run;

    // PC counts words, offsets are in words too
    assign pcPlus1    = pc + 8'd1;
    assign takeBranch = (branch && (zero ^ branchNe)) || jump;
    assign pcNext     = takeBranch ? pc + imm[7:0] : pcPlus1;   // Wraps mod 256

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= 8'd0;
        end else if (!run) begin
            pc <= 8'd0;           // Restart from 0 on next run
        end else begin
            pc <= pcNext;
        end
    end

    assign aluB = aluSrc ? imm : readData2;

    always_comb begin
        case (wbSel)
            wbMem:   writeData = memData;
            wbImm:   writeData = imm;
            wbLink:  writeData = {24'd0, pcPlus1};
            default: writeData = aluResult;
        endcase
    end

    // Commit reported before the writing edge
    assign commitValid = run && regWrite && (rd != 5'd0);
    assign commitReg   = rd;
    assign commitData  = writeData;
    assign commitPc    = pc;

    instrMem i_instrMem (
        .clock    (clock),
        .writeEn  (loadValid & loadReady),
        .writeAddr(loadAddr),
        .readAddr (pc),
        .writeData(loadData),
        .readData (instr)
    );

    controlUnit i_controlUnit (
        .instr       (instr),
        .regWrite    (regWrite),
        .memWrite    (memWrite),
        .memRead     (memRead),
        .aluSrc      (aluSrc),
        .branch      (branch),
        .branchNe    (branchNe),
        .jump        (jump),
        .loadUnsigned(loadUnsigned),
        .aluOp       (aluOp),
        .wbSel       (wbSel),
        .memSize     (memSize)
    );

    immGen i_immGen (
        .instr(instr),
        .imm  (imm)
    );

    registerFile i_registerFile (
        .clock    (clock),
        .arstN    (arstN),
        .writeEn  (regWrite & run),
        .readAddr1(instr.rType.rs1),
        .readAddr2(instr.rType.rs2),
        .writeAddr(rd),
        .writeData(writeData),
        .readData1(readData1),
        .readData2(readData2)
    );

    alu i_alu (
        .aluOp   (aluOp),
        .funcCode({instr[30], instr.rType.funct3}),
        .isImm   (aluSrc),
        .a       (readData1),
        .b       (aluB),
        .result  (aluResult),
        .zero    (zero)
    );

    dataMem i_dataMem (
        .clock       (clock),
        .writeEn     (memWrite & run),
        .readEn      (memRead),
        .loadUnsigned(loadUnsigned),
        .memSize     (memSize),
        .address     (aluResult[9:0]),
        .writeData   (readData2),
        .readData    (memData)
    );

endmodule

/* rtl/dataMem.sv */
`timescale 1ns/1ns

module dataMem
    import rvCorePkg::*;
(
    input  logic        clock,
    input  logic        writeEn,
    input  logic        readEn,
    input  logic        loadUnsigned,
    input  logic [1:0]  memSize,
    input  logic [9:0]  address,
    input  logic [31:0] writeData,
    output logic [31:0] readData
);

    logic [7:0]  mem [dmemBytes];
    logic [9:0]  addr1;
    logic [9:0]  addr2;
    logic [9:0]  addr3;
    logic [31:0] rawWord;
    logic [31:0] loadVal;

    // Little endian, byte addresses wrap in 10 bits
    assign addr1 = address + 10'd1;
    assign addr2 = address + 10'd2;
    assign addr3 = address + 10'd3;

    initial begin
        for (int i = 0; i < dmemBytes; i++) begin
            mem[i] = 8'd0;
        end
    end

    always_ff @(posedge clock) begin
        if (writeEn) begin
            mem[address] <= writeData[7:0];
            if (memSize != sizeByte) mem[addr1] <= writeData[15:8];  // sh, sw
            if (memSize == sizeWord) begin
                mem[addr2] <= writeData[23:16];
                mem[addr3] <= writeData[31:24];
            end
        end
    end

    assign rawWord = {mem[addr3], mem[addr2], mem[addr1], mem[address]};

    // Sign or zero extension
    always_comb begin
        case (memSize)
            sizeByte: loadVal = {{24{rawWord[7] & ~loadUnsigned}}, rawWord[7:0]};
            sizeHalf: loadVal = {{16{rawWord[15] & ~loadUnsigned}}, rawWord[15:0]};
            default:  loadVal = rawWord;
        endcase
    end

    assign readData = readEn ? loadVal : 32'd0;

endmodule

/* rtl/instrMem.sv */
`timescale 1ns/1ns

module instrMem
    import rvCorePkg::*;
(
    input  logic        clock,
    input  logic        writeEn,
    input  logic [7:0]  writeAddr,
    input  logic [7:0]  readAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readData
);

    logic [31:0] mem [imemWords];

    // Unloaded words read as zero, i.e. no-ops
    initial begin
        for (int i = 0; i < imemWords; i++) begin
            mem[i] = 32'd0;
        end
    end

    always_ff @(posedge clock) begin
        if (writeEn) mem[writeAddr] <= writeData;   // Program load only
    end

    assign readData = mem[readAddr];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ns

module alu
    import rvCorePkg::*;
(
    input  logic [1:0]  aluOp,
    input  logic [3:0]  funcCode,   // {instr[30], funct3}
    input  logic        isImm,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        zero
);

    logic [3:0] aluCtl;
    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Operation decode
    always_comb begin
        case (aluOp)
            aluAdd:    aluCtl = ctlAdd;
            aluBranch: aluCtl = ctlSub;
            default: begin
                case (funcCode[2:0])
                    f3Add:   aluCtl = (funcCode[3] && !isImm) ? ctlSub : ctlAdd;  // No subi
                    f3Sll:   aluCtl = ctlSll;
                    f3Slt:   aluCtl = ctlSlt;
                    f3Sltu:  aluCtl = ctlSltu;
                    f3Xor:   aluCtl = ctlXor;
                    f3Srl:   aluCtl = funcCode[3] ? ctlSra : ctlSrl;  // srai keeps bit 30
                    f3Or:    aluCtl = ctlOr;
                    f3And:   aluCtl = ctlAnd;
                    default: aluCtl = ctlAdd;
                endcase
            end
        endcase
    end

    always_comb begin
        case (aluCtl)
            ctlAnd:  result = a & b;
            ctlOr:   result = a | b;
            ctlXor:  result = a ^ b;
            ctlSub:  result = a - b;
            ctlSlt:  result = {31'd0, $signed(a) < $signed(b)};
            ctlSltu: result = {31'd0, a < b};
            ctlSll:  result = a << shamt;
            ctlSrl:  result = a >> shamt;
            ctlSra:  result = $unsigned($signed(a) >>> shamt);
            default: result = a + b;
        endcase
    end

    assign zero = (result == 32'd0);   // beq/bne compare

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ns

module registerFile (
    input  logic        clock,
    input  logic        arstN,
    input  logic        writeEn,
    input  logic [4:0]  readAddr1,
    input  logic [4:0]  readAddr2,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (writeEn && (writeAddr != 5'd0)) begin   // x0 stays zero
            regs[writeAddr] <= writeData;
        end
    end

    // Asynchronous reads
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

/* rtl/immGen.sv */
`timescale 1ns/1ns

module immGen
    import rvCorePkg::*;
(
    input  instrWord    instr,
    output logic [31:0] imm
);

    logic [11:0] branchOff;   // Offset in words, no implied zero bit
    logic [19:0] jumpOff;     // Same for jal

    assign branchOff = {instr.bType.imm12, instr.bType.imm11,
                        instr.bType.imm10to5, instr.bType.imm4to1};
    assign jumpOff   = {instr.uj.imm[19], instr.uj.imm[7:0],
                        instr.uj.imm[8], instr.uj.imm[18:9]};

    always_comb begin
        case (instr.rType.opcode)
            opI, opLoad: imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            opStore:     imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
            opBranch:    imm = {{20{branchOff[11]}}, branchOff};
            opJal:       imm = {{12{jumpOff[19]}}, jumpOff};
            opLui:       imm = {instr.uj.imm, 12'd0};        // Upper 20 bits, zeros below
            default:     imm = 32'd0;
        endcase
    end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/1ns

module controlUnit
    import rvCorePkg::*;
(
    input  instrWord   instr,
    output logic       regWrite,
    output logic       memWrite,
    output logic       memRead,
    output logic       aluSrc,
    output logic       branch,
    output logic       branchNe,
    output logic       jump,
    output logic       loadUnsigned,
    output logic [1:0] aluOp,
    output logic [1:0] wbSel,
    output logic [1:0] memSize
);

    logic [2:0] funct3;

    assign funct3 = instr.rType.funct3;

    always_comb begin
        // Defaults give a no-op
        regWrite     = 1'b0;
        memWrite     = 1'b0;
        memRead      = 1'b0;
        aluSrc       = 1'b0;
        branch       = 1'b0;
        branchNe     = 1'b0;
        jump         = 1'b0;
        loadUnsigned = 1'b0;
        aluOp        = aluAdd;
        wbSel        = wbAlu;
        memSize      = sizeWord;

        case (instr.rType.opcode)
            opR: begin
                regWrite = 1'b1;
                aluOp    = aluFunc;
            end
            opI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluFunc;
            end
            opLoad: begin
                regWrite     = 1'b1;
                memRead      = 1'b1;
                aluSrc       = 1'b1;                  // rs1 + offset
                wbSel        = wbMem;
                loadUnsigned = funct3[2];             // lbu, lhu
                memSize      = (funct3[1:0] == sizeByte) ? sizeByte :
                               (funct3[1:0] == sizeHalf) ? sizeHalf : sizeWord;
            end
            opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                memSize  = (funct3[1:0] == sizeByte) ? sizeByte :
                           (funct3[1:0] == sizeHalf) ? sizeHalf : sizeWord;
            end
            opBranch: begin
                aluOp    = aluBranch;
                branch   = (funct3 == f3Beq) || (funct3 == f3Bne);   // Others fall through
                branchNe = (funct3 == f3Bne);
            end
            opJal: begin
                regWrite = 1'b1;
                jump     = 1'b1;
                wbSel    = wbLink;
            end
            opLui: begin
                regWrite = 1'b1;
                wbSel    = wbImm;
            end
            default: ;                                 // Unknown opcode, nothing written
        endcase
    end

endmodule

/* rtl/rvCorePkg.sv */
package rvCorePkg;

    // Major opcodes
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opLui    = 7'b0110111;

    // funct3 for arithmetic and logic
    localparam logic [2:0] f3Add  = 3'b000;      // add, sub, addi
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Srl  = 3'b101;      // srl, sra and immediates
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    // funct3 for branches
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    // ALU op class from the control unit
    localparam logic [1:0] aluAdd    = 2'b00;    // Address calc
    localparam logic [1:0] aluBranch = 2'b01;    // Compare by subtract
    localparam logic [1:0] aluFunc   = 2'b10;    // Decode funct bits

    // ALU operations
    localparam logic [3:0] ctlAnd  = 4'b0000;
    localparam logic [3:0] ctlOr   = 4'b0001;
    localparam logic [3:0] ctlAdd  = 4'b0010;
    localparam logic [3:0] ctlXor  = 4'b0011;
    localparam logic [3:0] ctlSub  = 4'b0110;
    localparam logic [3:0] ctlSlt  = 4'b0111;
    localparam logic [3:0] ctlSltu = 4'b1000;
    localparam logic [3:0] ctlSll  = 4'b1001;
    localparam logic [3:0] ctlSrl  = 4'b1010;
    localparam logic [3:0] ctlSra  = 4'b1011;

    // Access size, same as funct3[1:0] of loads and stores
    localparam logic [1:0] sizeByte = 2'b00;
    localparam logic [1:0] sizeHalf = 2'b01;
    localparam logic [1:0] sizeWord = 2'b10;

    // Register write-back source
    localparam logic [1:0] wbAlu  = 2'b00;
    localparam logic [1:0] wbMem  = 2'b01;
    localparam logic [1:0] wbImm  = 2'b10;       // lui
    localparam logic [1:0] wbLink = 2'b11;       // jal

    localparam int imemWords = 256;              // 8-bit word address
    localparam int dmemBytes = 1024;             // 10-bit byte address

    // One instruction word, five field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm;                    // lui upper bits or scrambled jal offset
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uj;
    } instrWord;

endpackage
